/* axi_id_serialize_rd.f */
+incdir+hdl
hdl/axi_id_serialize_pkg.sv
hdl/tagged_rd_if.sv
hdl/slot_rd_if.sv
hdl/slot_rd_demux.sv
hdl/id_serializer.sv
hdl/slot_rd_mux.sv
hdl/axi_id_serialize_rd.sv
test/rd_mem_model.sv
test/tb_axi_id_serialize_rd.sv

/* Makefile */
# Verilator build and run for the AXI ID serializer read path

VERILATOR ?= verilator
TOP       ?= tb_axi_id_serialize_rd
FILELIST  ?= axi_id_serialize_rd.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j $(JOBS)

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard hdl/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# A failing run ends in $$fatal, so the exit status is nonzero
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

/* test/tb_axi_id_serialize_rd.sv */
/*
 * Testbench for the AXI ID serializer read path
 * Random reads over the full subordinate ID space against a
 * reordering memory model, checked by a per-ID scoreboard.
 */

`timescale 1ns/1ps
`default_nettype none

`include "axi_id_serialize_consts.svh"

module tb_axi_id_serialize_rd;

  localparam int NUM_READS   = 400;
  localparam int AR_LIMIT    = 300;
  localparam int DRAIN_LIMIT = 2000;
  localparam int NUM_IDS     = 1 << `SBR_ID_WIDTH;
  localparam axi_id_serialize_pkg::data_t DATA_KEY = 32'hA5A5_5A5A;

  // One accepted subordinate AR
  typedef struct packed {
    axi_id_serialize_pkg::sbr_id_t id;
    axi_id_serialize_pkg::addr_t   addr;
  } ar_rec_t;

  logic                           clk;
  logic                           rst_n;
  logic                           sbr_ar_valid;
  axi_id_serialize_pkg::sbr_id_t  sbr_ar_id;
  axi_id_serialize_pkg::addr_t    sbr_ar_addr;
  logic                           sbr_ar_ready;
  logic                           sbr_r_valid;
  axi_id_serialize_pkg::sbr_id_t  sbr_r_id;
  axi_id_serialize_pkg::data_t    sbr_r_data;
  axi_id_serialize_pkg::rd_resp_e sbr_r_resp;
  logic                           sbr_r_ready;
  logic                           mgr_ar_valid;
  axi_id_serialize_pkg::mgr_id_t  mgr_ar_id;
  axi_id_serialize_pkg::addr_t    mgr_ar_addr;
  logic                           mgr_ar_ready;
  logic                           mgr_r_valid;
  axi_id_serialize_pkg::mgr_id_t  mgr_r_id;
  axi_id_serialize_pkg::data_t    mgr_r_data;
  axi_id_serialize_pkg::rd_resp_e mgr_r_resp;
  logic                           mgr_r_ready;

  // Expected addresses per subordinate ID in arrival order
  axi_id_serialize_pkg::addr_t   exp_q [NUM_IDS][$];
  // ARs per slot that have not reached the manager yet
  ar_rec_t                       fwd_q [`NUM_SLOTS][$];
  // Reads outstanding at the manager and the subordinate ID behind them
  int                            mgr_out [`NUM_SLOTS];
  axi_id_serialize_pkg::sbr_id_t owner [`NUM_SLOTS];
  int                            ar_count;
  int                            r_count;

  initial clk = 1'b0;
  always #2 clk = ~clk;

  axi_id_serialize_rd axi_id_serialize_rd_i (
    .clk_i          ( clk          ),
    .rst_n_i        ( rst_n        ),
    .sbr_ar_valid_i ( sbr_ar_valid ),
    .sbr_ar_id_i    ( sbr_ar_id    ),
    .sbr_ar_addr_i  ( sbr_ar_addr  ),
    .sbr_ar_ready_o ( sbr_ar_ready ),
    .sbr_r_valid_o  ( sbr_r_valid  ),
    .sbr_r_id_o     ( sbr_r_id     ),
    .sbr_r_data_o   ( sbr_r_data   ),
    .sbr_r_resp_o   ( sbr_r_resp   ),
    .sbr_r_ready_i  ( sbr_r_ready  ),
    .mgr_ar_valid_o ( mgr_ar_valid ),
    .mgr_ar_id_o    ( mgr_ar_id    ),
    .mgr_ar_addr_o  ( mgr_ar_addr  ),
    .mgr_ar_ready_i ( mgr_ar_ready ),
    .mgr_r_valid_i  ( mgr_r_valid  ),
    .mgr_r_id_i     ( mgr_r_id     ),
    .mgr_r_data_i   ( mgr_r_data   ),
    .mgr_r_resp_i   ( mgr_r_resp   ),
    .mgr_r_ready_o  ( mgr_r_ready  )
  );

  rd_mem_model rd_mem_model_i (
    .clk_i      ( clk          ),
    .rst_n_i    ( rst_n        ),
    .ar_valid_i ( mgr_ar_valid ),
    .ar_id_i    ( mgr_ar_id    ),
    .ar_addr_i  ( mgr_ar_addr  ),
    .ar_ready_o ( mgr_ar_ready ),
    .r_valid_o  ( mgr_r_valid  ),
    .r_id_o     ( mgr_r_id     ),
    .r_data_o   ( mgr_r_data   ),
    .r_resp_o   ( mgr_r_resp   ),
    .r_ready_i  ( mgr_r_ready  )
  );

  task automatic abort_run(input string why);
    $display("%s (t=%0t)", why, $time);
    $display(">>> FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    abort_run($sformatf("MISMATCH %s: got 0x%08h, expected 0x%08h", name, got, exp));
  endtask

  // RRESP rule of the memory model
  function automatic axi_id_serialize_pkg::rd_resp_e expected_resp(
      input axi_id_serialize_pkg::addr_t addr);
    return addr[31] ? axi_id_serialize_pkg::RESP_SLVERR : axi_id_serialize_pkg::RESP_OKAY;
  endfunction

  function automatic int slot_of(input axi_id_serialize_pkg::sbr_id_t id);
    return int'(id) % `NUM_SLOTS;
  endfunction

  task automatic check_idle();
    assert (!mgr_ar_valid) else report_mismatch("mgr_ar_valid_o", 32'(mgr_ar_valid), 32'h0);
    assert (!sbr_r_valid) else report_mismatch("sbr_r_valid_o", 32'(sbr_r_valid), 32'h0);
  endtask

  // Holds the AR stable until the DUT takes it
  task automatic send_read(input axi_id_serialize_pkg::sbr_id_t id,
                           input axi_id_serialize_pkg::addr_t addr);
    int waited;
    waited = 0;
    @(negedge clk);
    sbr_ar_valid = 1'b1;
    sbr_ar_id    = id;
    sbr_ar_addr  = addr;
    do begin
      @(posedge clk);
      waited++;
      if (waited > AR_LIMIT) begin
        abort_run("subordinate AR was not accepted before the timeout");
      end
    end while (!sbr_ar_ready);
  endtask

  // Random R back-pressure driven on the falling edge
  task automatic drive_r_ready();
    forever begin
      @(negedge clk);
      sbr_r_ready = rst_n && ($urandom_range(3) != 0);
    end
  endtask

  task automatic wait_for_drain();
    int cycles;
    cycles = 0;
    while (r_count != ar_count) begin
      @(negedge clk);
      cycles++;
      if (cycles > DRAIN_LIMIT) begin
        abort_run("outstanding reads did not drain before the timeout");
      end
    end
  endtask

  task automatic check_queues_empty();
    for (int s = 0; s < `NUM_SLOTS; s++) begin
      assert (fwd_q[s].size() == 0)
        else abort_run($sformatf("AR of slot %0d never reached the manager", s));
      assert (mgr_out[s] == 0)
        else report_mismatch("manager reads outstanding", 32'(mgr_out[s]), 32'h0);
    end
  endtask

  // Each cycle handles R before manager AR and manager AR before new subordinate AR
  always @(posedge clk) begin : scoreboard
    ar_rec_t                     rec;
    axi_id_serialize_pkg::addr_t addr;
    int                          slot;
    if (rst_n) begin
      // Manager R ready follows subordinate R ready while data is offered
      if (mgr_r_valid) begin
        assert (mgr_r_ready == sbr_r_ready)
          else report_mismatch("mgr_r_ready_o", 32'(mgr_r_ready), 32'(sbr_r_ready));
      end
      if (sbr_r_valid && sbr_r_ready) begin
        assert (exp_q[sbr_r_id].size() > 0)
          else abort_run($sformatf("R beat on ID 0x%0h with no read pending", sbr_r_id));
        // Restored ID must be the one the slot holds at the manager
        assert (sbr_r_id == owner[mgr_r_id])
          else report_mismatch("sbr_r_id_o", 32'(sbr_r_id), 32'(owner[mgr_r_id]));
        addr = exp_q[sbr_r_id].pop_front();
        assert (sbr_r_data == (addr ^ DATA_KEY))
          else report_mismatch("sbr_r_data_o", sbr_r_data, addr ^ DATA_KEY);
        assert (sbr_r_resp == expected_resp(addr))
          else report_mismatch("sbr_r_resp_o", 32'(sbr_r_resp), 32'(expected_resp(addr)));
        r_count++;
      end
      if (mgr_r_valid && mgr_r_ready) begin
        mgr_out[mgr_r_id]--;
      end
      if (mgr_ar_valid && mgr_ar_ready) begin
        slot = int'(mgr_ar_id);
        assert (fwd_q[slot].size() > 0)
          else abort_run($sformatf("manager AR on ID %0d with no AR pending", slot));
        rec = fwd_q[slot].pop_front();
        assert (mgr_ar_addr == rec.addr)
          else report_mismatch("mgr_ar_addr_o", mgr_ar_addr, rec.addr);
        if (mgr_out[slot] == 0) begin
          owner[slot] = rec.id;
        end else begin
          assert (rec.id == owner[slot])
            else abort_run($sformatf("manager ID %0d mixes subordinate IDs 0x%0h and 0x%0h",
                                     slot, owner[slot], rec.id));
        end
        mgr_out[slot]++;
        assert (mgr_out[slot] <= `MAX_TXNS_PER_ID)
          else abort_run($sformatf("too many reads outstanding on manager ID %0d", slot));
      end
      if (sbr_ar_valid && sbr_ar_ready) begin
        rec.id   = sbr_ar_id;
        rec.addr = sbr_ar_addr;
        exp_q[sbr_ar_id].push_back(sbr_ar_addr);
        fwd_q[slot_of(sbr_ar_id)].push_back(rec);
        ar_count++;
      end
    end
  end

  initial begin
    int gap;
    axi_id_serialize_pkg::sbr_id_t id;
    axi_id_serialize_pkg::addr_t   addr;
    void'($urandom(32'h6dd3));
    rst_n        = 1'b0;
    sbr_ar_valid = 1'b0;
    sbr_ar_id    = '0;
    sbr_ar_addr  = '0;
    sbr_r_ready  = 1'b0;
    ar_count     = 0;
    r_count      = 0;
    id           = '0;
    for (int s = 0; s < `NUM_SLOTS; s++) begin
      mgr_out[s] = 0;
      owner[s]   = '0;
    end
    fork
      drive_r_ready();
    join_none
    // The first edge applies reset and the outputs stay idle after it
    @(posedge clk);
    repeat (4) begin
      @(posedge clk);
      check_idle();
    end
    @(negedge clk);
    rst_n = 1'b1;
    @(posedge clk);
    check_idle();
    for (int n = 0; n < NUM_READS; n++) begin
      // Runs of one ID fill a slot up to its limit
      if ($urandom_range(1) == 0) begin
        id = axi_id_serialize_pkg::sbr_id_t'($urandom_range(NUM_IDS - 1));
      end
      addr = $urandom();
      send_read(id, addr);
      if ($urandom_range(3) == 0) begin
        @(negedge clk);
        sbr_ar_valid = 1'b0;
        gap = $urandom_range(4);
        repeat (gap) @(negedge clk);
      end
    end
    @(negedge clk);
    sbr_ar_valid = 1'b0;
    wait_for_drain();
    // Extra cycles expose a duplicated R beat
    repeat (20) @(negedge clk);
    check_queues_empty();
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* test/rd_mem_model.sv */
/*
 * Manager-side memory model for the read path
 * Accepts AR with random ready, keeps one queue per manager ID and
 * answers from a random busy ID, so order changes only across IDs.
 * Data is the address XOR a fixed key, SLVERR when bit 31 is set.
 */

`timescale 1ns/1ps
`default_nettype none

`include "axi_id_serialize_consts.svh"

module rd_mem_model (
  input  wire logic                      clk_i,
  input  wire logic                      rst_n_i,
  input  wire logic                      ar_valid_i,
  input  axi_id_serialize_pkg::mgr_id_t  ar_id_i,
  input  axi_id_serialize_pkg::addr_t    ar_addr_i,
  output logic                           ar_ready_o,
  output logic                           r_valid_o,
  output axi_id_serialize_pkg::mgr_id_t  r_id_o,
  output axi_id_serialize_pkg::data_t    r_data_o,
  output axi_id_serialize_pkg::rd_resp_e r_resp_o,
  input  wire logic                      r_ready_i
);

  // Pending read addresses per manager ID, oldest first
  axi_id_serialize_pkg::addr_t pend_q [`NUM_SLOTS][$];

  initial begin
    logic                        r_done;
    int                          n_busy;
    int                          pick;
    int                          sel;
    axi_id_serialize_pkg::addr_t addr;
    ar_ready_o = 1'b0;
    r_valid_o  = 1'b0;
    r_id_o     = '0;
    r_data_o   = '0;
    r_resp_o   = axi_id_serialize_pkg::RESP_OKAY;
    forever begin
      // Handshakes are taken at the rising edge
      @(posedge clk_i);
      r_done = r_valid_o && r_ready_i;
      if (rst_n_i && ar_valid_i && ar_ready_o) begin
        pend_q[ar_id_i].push_back(ar_addr_i);
      end
      // Outputs change on the falling edge
      @(negedge clk_i);
      if (!rst_n_i) begin
        ar_ready_o = 1'b0;
        r_valid_o  = 1'b0;
      end else begin
        ar_ready_o = ($urandom_range(2) != 0);
        if (r_done) begin
          r_valid_o = 1'b0;
        end
        // Random gap before the next beat
        if (!r_valid_o && ($urandom_range(2) == 0)) begin
          n_busy = 0;
          for (int i = 0; i < `NUM_SLOTS; i++) begin
            if (pend_q[i].size() > 0) begin
              n_busy++;
            end
          end
          if (n_busy > 0) begin
            // n-th busy ID, n picked at random
            pick = $urandom_range(n_busy - 1);
            sel  = 0;
            for (int i = 0; i < `NUM_SLOTS; i++) begin
              if (pend_q[i].size() > 0) begin
                if (pick == 0) begin
                  sel = i;
                end
                pick--;
              end
            end
            addr      = pend_q[sel].pop_front();
            r_valid_o = 1'b1;
            r_id_o    = axi_id_serialize_pkg::mgr_id_t'(sel);
            r_data_o  = addr ^ 32'hA5A5_5A5A;
            r_resp_o  = addr[31] ? axi_id_serialize_pkg::RESP_SLVERR
                                 : axi_id_serialize_pkg::RESP_OKAY;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/axi_id_serialize_rd.sv */
/*
 * AXI ID serializer, read path, top level
 * Maps a wide subordinate ID space onto NUM_SLOTS manager IDs.
 * Reads with different IDs that share a slot are serialized,
 * and the original ID is restored on the R channel.
 */

`timescale 1ns/1ps
`default_nettype none

`include "axi_id_serialize_consts.svh"

module axi_id_serialize_rd (
  input  wire logic                      clk_i,
  input  wire logic                      rst_n_i,

  // Subordinate AR
  input  wire logic                      sbr_ar_valid_i,
  input  axi_id_serialize_pkg::sbr_id_t  sbr_ar_id_i,
  input  axi_id_serialize_pkg::addr_t    sbr_ar_addr_i,
  output logic                           sbr_ar_ready_o,

  // Subordinate R
  output logic                           sbr_r_valid_o,
  output axi_id_serialize_pkg::sbr_id_t  sbr_r_id_o,
  output axi_id_serialize_pkg::data_t    sbr_r_data_o,
  output axi_id_serialize_pkg::rd_resp_e sbr_r_resp_o,
  input  wire logic                      sbr_r_ready_i,

  // Manager AR
  output logic                           mgr_ar_valid_o,
  output axi_id_serialize_pkg::mgr_id_t  mgr_ar_id_o,
  output axi_id_serialize_pkg::addr_t    mgr_ar_addr_o,
  input  wire logic                      mgr_ar_ready_i,

  // Manager R
  input  wire logic                      mgr_r_valid_i,
  input  axi_id_serialize_pkg::mgr_id_t  mgr_r_id_i,
  input  axi_id_serialize_pkg::data_t    mgr_r_data_i,
  input  axi_id_serialize_pkg::rd_resp_e mgr_r_resp_i,
  output logic                           mgr_r_ready_o
);

  // Demux to serializers
  tagged_rd_if tag_if [`NUM_SLOTS] ();

  // Serializers to mux
  slot_rd_if slot_if [`NUM_SLOTS] ();

  slot_rd_demux slot_rd_demux_i (
    .sbr_ar_valid_i ( sbr_ar_valid_i ),
    .sbr_ar_id_i    ( sbr_ar_id_i    ),
    .sbr_ar_addr_i  ( sbr_ar_addr_i  ),
    .sbr_ar_ready_o ( sbr_ar_ready_o ),
    .sbr_r_valid_o  ( sbr_r_valid_o  ),
    .sbr_r_id_o     ( sbr_r_id_o     ),
    .sbr_r_data_o   ( sbr_r_data_o   ),
    .sbr_r_resp_o   ( sbr_r_resp_o   ),
    .sbr_r_ready_i  ( sbr_r_ready_i  ),
    .slots_o        ( tag_if         )
  );

  // One serializer per manager ID
  for (genvar i = 0; i < `NUM_SLOTS; i++) begin : gen_ser
    id_serializer id_serializer_i (
      .clk_i   ( clk_i      ),
      .rst_n_i ( rst_n_i    ),
      .up_i    ( tag_if[i]  ),
      .down_o  ( slot_if[i] )
    );
  end

  slot_rd_mux slot_rd_mux_i (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .slots_i        ( slot_if        ),
    .mgr_ar_valid_o ( mgr_ar_valid_o ),
    .mgr_ar_id_o    ( mgr_ar_id_o    ),
    .mgr_ar_addr_o  ( mgr_ar_addr_o  ),
    .mgr_ar_ready_i ( mgr_ar_ready_i ),
    .mgr_r_valid_i  ( mgr_r_valid_i  ),
    .mgr_r_id_i     ( mgr_r_id_i     ),
    .mgr_r_data_i   ( mgr_r_data_i   ),
    .mgr_r_resp_i   ( mgr_r_resp_i   ),
    .mgr_r_ready_o  ( mgr_r_ready_o  )
  );

endmodule

`default_nettype wire

/* hdl/slot_rd_mux.sv */
/*
 * Slot mux
 * Round-robin arbitration of slot ARs into a one-entry output
 * register, manager ID set to the slot index.
 * R is routed back to the slot named by the manager ID.
 */

`timescale 1ns/1ps
`default_nettype none

`include "axi_id_serialize_consts.svh"

module slot_rd_mux (
  input  wire logic                           clk_i,
  input  wire logic                           rst_n_i,
  slot_rd_if.dst                              slots_i [`NUM_SLOTS],
  output logic                                mgr_ar_valid_o,
  output axi_id_serialize_pkg::mgr_id_t       mgr_ar_id_o,
  output axi_id_serialize_pkg::addr_t         mgr_ar_addr_o,
  input  wire logic                           mgr_ar_ready_i,
  input  wire logic                           mgr_r_valid_i,
  input  axi_id_serialize_pkg::mgr_id_t       mgr_r_id_i,
  input  axi_id_serialize_pkg::data_t         mgr_r_data_i,
  input  axi_id_serialize_pkg::rd_resp_e      mgr_r_resp_i,
  output logic                                mgr_r_ready_o
);

  // Flattened slot signals
  logic                        slot_ar_valid [`NUM_SLOTS];
  axi_id_serialize_pkg::addr_t slot_ar_addr  [`NUM_SLOTS];
  logic                        slot_r_ready  [`NUM_SLOTS];

  // Arbiter
  axi_id_serialize_pkg::slot_idx_t last_q;
  axi_id_serialize_pkg::slot_idx_t pick_idx;
  logic                            pick_valid;

  // Output register
  logic                            out_valid_q;
  axi_id_serialize_pkg::mgr_id_t   out_id_q;
  axi_id_serialize_pkg::addr_t     out_addr_q;
  logic                            load_en;
  logic                            grant;

  // Free now, or drained this cycle
  assign load_en = !out_valid_q || mgr_ar_ready_i;
  assign grant   = load_en && pick_valid;

  for (genvar i = 0; i < `NUM_SLOTS; i++) begin : gen_slot
    assign slot_ar_valid[i]   = slots_i[i].ar_valid;
    assign slot_ar_addr[i]    = slots_i[i].ar_addr;
    assign slots_i[i].ar_ready = grant && (pick_idx == i);

    // R valid only toward the addressed slot
    assign slots_i[i].r_valid =
      mgr_r_valid_i && (mgr_r_id_i == axi_id_serialize_pkg::mgr_id_t'(i));
    assign slots_i[i].r_data  = mgr_r_data_i;
    assign slots_i[i].r_resp  = mgr_r_resp_i;
    assign slot_r_ready[i]    = slots_i[i].r_ready;
  end

  // Search starts one past the last winner
  always_comb begin
    axi_id_serialize_pkg::slot_idx_t cand;
    pick_valid = 1'b0;
    pick_idx   = last_q;
    for (int k = 1; k <= `NUM_SLOTS; k++) begin
      cand = axi_id_serialize_pkg::slot_idx_t'((int'(last_q) + k) % `NUM_SLOTS);
      if (!pick_valid && slot_ar_valid[cand]) begin
        pick_valid = 1'b1;
        pick_idx   = cand;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_valid_q <= 1'b0;
      last_q      <= '0;
    end else begin
      if (load_en) begin
        out_valid_q <= pick_valid;
      end
      if (grant) begin
        last_q <= pick_idx;
      end
    end
  end

  // AR payload, loaded with the winner
  always_ff @(posedge clk_i) begin
    if (grant) begin
      out_id_q   <= axi_id_serialize_pkg::mgr_id_t'(pick_idx);
      out_addr_q <= slot_ar_addr[pick_idx];
    end
  end

  assign mgr_ar_valid_o = out_valid_q;
  assign mgr_ar_id_o    = out_id_q;
  assign mgr_ar_addr_o  = out_addr_q;

  // Ready comes from the addressed slot
  assign mgr_r_ready_o = slot_r_ready[mgr_r_id_i];

endmodule

`default_nettype wire

/* hdl/id_serializer.sv */
/*
 * Per-slot ID serializer
 * Admits reads of one subordinate ID at a time into the slot,
 * counts them, and puts the held ID back onto returning R beats.
 */

`timescale 1ns/1ps
`default_nettype none

`include "axi_id_serialize_consts.svh"

module id_serializer (
  input  wire logic clk_i,
  input  wire logic rst_n_i,
  tagged_rd_if.dst  up_i,
  slot_rd_if.src    down_o
);

  // ID of the reads now in flight
  axi_id_serialize_pkg::sbr_id_t cur_id_q;

  // Outstanding reads in this slot
  axi_id_serialize_pkg::txn_cnt_t cnt_q;
  axi_id_serialize_pkg::txn_cnt_t cnt_d;

  logic id_ok;
  logic room_ok;
  logic ar_pass;
  logic ar_fire;
  logic r_fire;

  // An empty slot takes any ID and a busy one only the held ID
  assign id_ok   = (cnt_q == '0) || (up_i.ar_id == cur_id_q);
  assign room_ok = cnt_q < axi_id_serialize_pkg::txn_cnt_t'(`MAX_TXNS_PER_ID);
  assign ar_pass = id_ok && room_ok;

  // Gate both directions of the AR handshake
  // The gate only flips on counter or ID changes and keeps valid stable
  assign down_o.ar_valid = up_i.ar_valid && ar_pass;
  assign down_o.ar_addr  = up_i.ar_addr;
  assign up_i.ar_ready   = down_o.ar_ready && ar_pass;

  // R passes straight through
  assign up_i.r_valid    = down_o.r_valid;
  assign up_i.r_data     = down_o.r_data;
  assign up_i.r_resp     = down_o.r_resp;
  assign up_i.r_id       = cur_id_q;
  assign down_o.r_ready  = up_i.r_ready;

  assign ar_fire = down_o.ar_valid && down_o.ar_ready;
  assign r_fire  = down_o.r_valid && down_o.r_ready;

  // Count up on AR and down on R
  // AR and R in the same cycle leave the count unchanged
  always_comb begin
    cnt_d = cnt_q;
    if (ar_fire && !r_fire) begin
      cnt_d = cnt_q + 1'b1;
    end else if (r_fire && !ar_fire) begin
      cnt_d = cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // Held ID follows each admitted AR
  always_ff @(posedge clk_i) begin
    if (ar_fire) begin
      cur_id_q <= up_i.ar_id;
    end
  end

endmodule

`default_nettype wire

/* hdl/slot_rd_demux.sv */
/*
 * Slot demux
 * Steers subordinate AR to slot (ID modulo slot count) and
 * merges the slot R channels back onto the subordinate port.
 */

`timescale 1ns/1ps
`default_nettype none

`include "axi_id_serialize_consts.svh"

module slot_rd_demux (
  input  wire logic                           sbr_ar_valid_i,
  input  axi_id_serialize_pkg::sbr_id_t       sbr_ar_id_i,
  input  axi_id_serialize_pkg::addr_t         sbr_ar_addr_i,
  output logic                                sbr_ar_ready_o,
  output logic                                sbr_r_valid_o,
  output axi_id_serialize_pkg::sbr_id_t       sbr_r_id_o,
  output axi_id_serialize_pkg::data_t         sbr_r_data_o,
  output axi_id_serialize_pkg::rd_resp_e      sbr_r_resp_o,
  input  wire logic                           sbr_r_ready_i,
  tagged_rd_if.src                            slots_o [`NUM_SLOTS]
);

  axi_id_serialize_pkg::slot_idx_t ar_sel;

  // Flattened view of the slot side, interface arrays need constant indices
  logic                           slot_ar_ready [`NUM_SLOTS];
  logic                           slot_r_valid  [`NUM_SLOTS];
  axi_id_serialize_pkg::sbr_id_t  slot_r_id     [`NUM_SLOTS];
  axi_id_serialize_pkg::data_t    slot_r_data   [`NUM_SLOTS];
  axi_id_serialize_pkg::rd_resp_e slot_r_resp   [`NUM_SLOTS];

  // Slot number is the low part of the ID
  assign ar_sel = axi_id_serialize_pkg::slot_idx_t'(sbr_ar_id_i % `NUM_SLOTS);

  for (genvar i = 0; i < `NUM_SLOTS; i++) begin : gen_slot
    // Valid only to the selected slot, payload to all
    assign slots_o[i].ar_valid = sbr_ar_valid_i && (ar_sel == i);
    assign slots_o[i].ar_id    = sbr_ar_id_i;
    assign slots_o[i].ar_addr  = sbr_ar_addr_i;
    assign slot_ar_ready[i]    = slots_o[i].ar_ready;

    assign slot_r_valid[i] = slots_o[i].r_valid;
    assign slot_r_id[i]    = slots_o[i].r_id;
    assign slot_r_data[i]  = slots_o[i].r_data;
    assign slot_r_resp[i]  = slots_o[i].r_resp;
    // Ready only reaches the slot that presents data
    assign slots_o[i].r_ready = sbr_r_ready_i && slot_r_valid[i];
  end

  assign sbr_ar_ready_o = slot_ar_ready[ar_sel];

  // Single manager R port, so one slot valid at most
  always_comb begin
    sbr_r_valid_o = 1'b0;
    sbr_r_id_o    = slot_r_id[0];
    sbr_r_data_o  = slot_r_data[0];
    sbr_r_resp_o  = slot_r_resp[0];
    for (int i = 0; i < `NUM_SLOTS; i++) begin
      if (slot_r_valid[i]) begin
        sbr_r_valid_o = 1'b1;
        sbr_r_id_o    = slot_r_id[i];
        sbr_r_data_o  = slot_r_data[i];
        sbr_r_resp_o  = slot_r_resp[i];
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/slot_rd_if.sv */
/*
 * Slot read channel pair
 * AR and R between one serializer and the slot mux.
 * No ID here, the slot index stands in for it.
 */

`timescale 1ns/1ps
`default_nettype none

interface slot_rd_if;

  // AR channel
  logic                        ar_valid;
  logic                        ar_ready;
  axi_id_serialize_pkg::addr_t ar_addr;

  // R channel
  logic                           r_valid;
  logic                           r_ready;
  axi_id_serialize_pkg::data_t    r_data;
  axi_id_serialize_pkg::rd_resp_e r_resp;

  // Serializer side
  modport src (
    output ar_valid, ar_addr, r_ready,
    input  ar_ready, r_valid, r_data, r_resp
  );

  // Mux side
  modport dst (
    input  ar_valid, ar_addr, r_ready,
    output ar_ready, r_valid, r_data, r_resp
  );

endinterface

`default_nettype wire

/* hdl/tagged_rd_if.sv */
/*
 * Tagged read channel pair
 * AR and R between the slot demux and one serializer.
 * Still carries the full subordinate ID in both directions.
 */

`timescale 1ns/1ps
`default_nettype none

interface tagged_rd_if;

  // AR channel
  logic                          ar_valid;
  logic                          ar_ready;
  axi_id_serialize_pkg::sbr_id_t ar_id;
  axi_id_serialize_pkg::addr_t   ar_addr;

  // R channel
  logic                           r_valid;
  logic                           r_ready;
  axi_id_serialize_pkg::sbr_id_t  r_id;
  axi_id_serialize_pkg::data_t    r_data;
  axi_id_serialize_pkg::rd_resp_e r_resp;

  // Demux side
  modport src (
    output ar_valid, ar_id, ar_addr, r_ready,
    input  ar_ready, r_valid, r_id, r_data, r_resp
  );

  // Serializer side
  modport dst (
    input  ar_valid, ar_id, ar_addr, r_ready,
    output ar_ready, r_valid, r_id, r_data, r_resp
  );

endinterface

`default_nettype wire

/* hdl/axi_id_serialize_pkg.sv */
/*
 * AXI ID serializer, read path
 * Common types for IDs, payload, slot index, counters and responses.
 */

`default_nettype none

`include "axi_id_serialize_consts.svh"

package axi_id_serialize_pkg;

  // Wide ID as seen on the subordinate port
  typedef logic [`SBR_ID_WIDTH-1:0] sbr_id_t;

  // Narrow ID driven on the manager port
  typedef logic [`MGR_ID_WIDTH-1:0] mgr_id_t;

  // Slot select, also the manager ID value
  typedef logic [$clog2(`NUM_SLOTS)-1:0] slot_idx_t;

  // Payload
  typedef logic [`ADDR_WIDTH-1:0] addr_t;
  typedef logic [`DATA_WIDTH-1:0] data_t;

  // Needs to reach MAX_TXNS_PER_ID itself, hence the +1
  typedef logic [$clog2(`MAX_TXNS_PER_ID+1)-1:0] txn_cnt_t;

  // AXI RRESP encoding
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } rd_resp_e;

endpackage

`default_nettype wire

/* hdl/axi_id_serialize_consts.svh */
/*
 * AXI ID serializer, read path
 * Build-time constants shared by the package and the RTL modules.
 * Widths, slot count and the per-slot outstanding read limit.
 */

`ifndef AXI_ID_SERIALIZE_CONSTS_SVH
`define AXI_ID_SERIALIZE_CONSTS_SVH

// ID width at the subordinate port
`define SBR_ID_WIDTH 4

// ID width at the manager port
`define MGR_ID_WIDTH 2

// Distinct manager IDs, one per slot
`define NUM_SLOTS 4

// Outstanding reads allowed in one slot
`define MAX_TXNS_PER_ID 4

// Address width on both ports
`define ADDR_WIDTH 32

// Data width on both ports
`define DATA_WIDTH 32

`endif
